//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_trivium
FILELIST  = compile.f
BUILD_DIR = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
+incdir+.
trivium_pkg.sv
trivium_core.sv
trivium_ctrl.sv
trivium_cipher.sv
tb_trivium.sv

//--- tb_trivium_model.svh
`ifndef TB_TRIVIUM_MODEL_SVH
`define TB_TRIVIUM_MODEL_SVH

localparam int MODEL_INIT_ROUNDS = 4 * 288;

bit [288:1] ms;                         // Reference state s1..s288
bit [31:0]  lfsr_state = 32'ha6c6;

string      row_name[$];
bit [79:0]  row_key[$];
bit [79:0]  row_iv[$];
int         row_bytes[$];
bit         row_rand[$];
int         row_gap[$];
bit         row_early[$];

task automatic add_row(input string name, input bit [79:0] k, input bit [79:0] v,
                       input int nbytes, input bit rnd, input int gap, input bit early);
    row_name.push_back(name);
    row_key.push_back(k);
    row_iv.push_back(v);
    row_bytes.push_back(nbytes);
    row_rand.push_back(rnd);
    row_gap.push_back(gap);
    row_early.push_back(early);
endtask

// Each row holds name, key, iv, byte count, random data flag, strobe gap and early strobe flag
task automatic build_table();
    add_row("zero_key_iv", 80'h0, 80'h0, 16, 1'b0, 0, 1'b0);
    add_row("ones_key_iv", {80{1'b1}}, {80{1'b1}}, 16, 1'b0, 1, 1'b0);
    add_row("single_bits", 80'h8000_0000_0000_0000_0000, 80'h1, 12, 1'b0, 0, 1'b0);
    add_row("mixed_keystream", 80'h0f62_b508_5bae_0154_a7fa,
            80'h288f_f65d_c42b_92f9_60c7, 24, 1'b0, 0, 1'b0);
    add_row("rand_back_to_back", 80'h3c1a_77e0_94d2_0b5f_c8a1,
            80'h5e00_1234_abcd_9876_0fed, 40, 1'b1, 0, 1'b0);
    add_row("rand_gapped", 80'h9a4b_c0de_2211_7f3e_5d06,
            80'h0042_8135_e6f9_a0b7_c3d4, 20, 1'b1, 3, 1'b0);
    add_row("early_strobe", 80'hdead_0beef_0000_1111_2, 80'h7777_6666_5555_4444_3333,
            8, 1'b0, 0, 1'b1);
    add_row("restart_new_key", 80'h1234_5678_9abc_def0_1357,
            80'hfedc_ba98_7654_3210_2468, 16, 1'b1, 2, 1'b0);
endtask

// One Galois step returns the bit shifted out
function automatic bit lfsr_bit();
    bit b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return b;
endfunction

function automatic bit [7:0] random_byte();
    bit [7:0] v;
    for (int i = 0; i < 8; i++) begin
        v[i] = lfsr_bit();
    end
    return v;
endfunction

// One published Trivium round returning its keystream bit
function automatic bit model_round();
    bit t1;
    bit t2;
    bit t3;
    bit z;
    t1 = ms[66] ^ ms[93];
    t2 = ms[162] ^ ms[177];
    t3 = ms[243] ^ ms[288];
    z  = t1 ^ t2 ^ t3;
    t1 = t1 ^ (ms[91] & ms[92]) ^ ms[171];
    t2 = t2 ^ (ms[175] & ms[176]) ^ ms[264];
    t3 = t3 ^ (ms[286] & ms[287]) ^ ms[69];
    ms[93:1]    = {ms[92:1], t3};
    ms[177:94]  = {ms[176:94], t1};
    ms[288:178] = {ms[287:178], t2};
    return z;
endfunction

// Load and run the full warm-up
task automatic model_load(input bit [79:0] k, input bit [79:0] v);
    ms = '0;
    for (int i = 0; i < 80; i++) begin
        ms[i + 1]  = k[i];
        ms[94 + i] = v[i];
    end
    ms[288:286] = 3'b111;
    for (int i = 0; i < MODEL_INIT_ROUNDS; i++) begin
        void'(model_round());
    end
endtask

function automatic bit [7:0] model_byte();
    bit [7:0] z;
    for (int i = 0; i < 8; i++) begin
        z[i] = model_round();                   // First bit lands in bit 0
    end
    return z;
endfunction

`endif

//--- tb_trivium.sv
`default_nettype none

module tb_trivium;

    localparam int WARM_EDGES = 144;    // Edges after the start edge with ready low
    localparam int EARLY_EDGE = 60;

    logic        clk;
    logic        rst;
    logic        start;
    logic [79:0] key;
    logic [79:0] iv;
    logic        data_valid;
    logic [7:0]  data_in;
    logic        ready;
    logic        out_valid;
    logic [7:0]  data_out;

    string cur_name;
    int    row_errors;
    int    total_errors;
    int    tests_run;
    int    tests_failed;
    bit    table_built;

    `include "tb_trivium_model.svh"

    trivium_cipher dut_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .key        (key),
        .iv         (iv),
        .data_valid (data_valid),
        .data_in    (data_in),
        .ready      (ready),
        .out_valid  (out_valid),
        .data_out   (data_out)
    );

    always #4 clk = ~clk;

    task automatic expect_level(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s: %s expected %0b actual %0b", cur_name, what, exp, act);
            row_errors++;
        end
    endtask

    task automatic compare_byte(input string what, input logic [7:0] exp,
                                input logic [7:0] act);
        if (act !== exp) begin
            $display("error %s: %s expected %h actual %h", cur_name, what, exp, act);
            row_errors++;
        end
    endtask

    task automatic finish_test(input int nbytes);
        tests_run++;
        total_errors += row_errors;
        if (row_errors == 0) begin
            $display("test %s: ok, %0d bytes", cur_name, nbytes);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_name, row_errors);
        end
    endtask

    task automatic run_row(input int r);
        logic [7:0] exp_byte;
        int         k;
        cur_name   = row_name[r];
        row_errors = 0;
        // An early row also strobes data with start, which must lose
        start      = 1'b1;
        key        = row_key[r];
        iv         = row_iv[r];
        data_valid = row_early[r];
        data_in    = 8'h5a;
        model_load(row_key[r], row_iv[r]);
        for (k = 0; k <= WARM_EDGES; k++) begin
            @(negedge clk);
            start = 1'b0;
            expect_level($sformatf("ready after edge %0d", k), k == WARM_EDGES, ready);
            expect_level($sformatf("out_valid after edge %0d", k), 1'b0, out_valid);
            data_valid = row_early[r] && (k == EARLY_EDGE);
        end
        for (int b = 0; b < row_bytes[r]; b++) begin
            data_valid = 1'b1;
            data_in    = row_rand[r] ? random_byte() : 8'h00;
            exp_byte   = data_in ^ model_byte();
            @(negedge clk);
            data_valid = 1'b0;
            expect_level($sformatf("out_valid for byte %0d", b), 1'b1, out_valid);
            compare_byte($sformatf("data_out byte %0d", b), exp_byte, data_out);
            expect_level("ready during data", 1'b1, ready);
            repeat (row_gap[r]) begin
                @(negedge clk);
                expect_level($sformatf("out_valid in gap after byte %0d", b), 1'b0,
                             out_valid);
            end
        end
        @(negedge clk);
        expect_level("out_valid after last byte", 1'b0, out_valid);
        finish_test(row_bytes[r]);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        key          = '0;
        iv           = '0;
        data_valid   = 1'b0;
        data_in      = '0;
        row_errors   = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        table_built  = 1'b0;
        build_table();
        table_built = 1'b1;

        repeat (5) @(negedge clk);
        rst        = 1'b0;
        cur_name   = "reset_state";
        row_errors = 0;
        expect_level("ready", 1'b0, ready);
        expect_level("out_valid", 1'b0, out_valid);
        compare_byte("data_out", 8'h00, data_out);
        finish_test(0);

        for (int r = 0; r < row_name.size(); r++) begin
            run_row(r);
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        wait (table_built);
        limit = 10;                             // Reset cycles
        for (int r = 0; r < row_name.size(); r++) begin
            limit += 145 + row_bytes[r] * (row_gap[r] + 2) + 20;
        end
        repeat (limit) @(posedge clk);
        $display("timeout waiting for ready or output after %0d cycles", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- trivium_cipher.sv
`default_nettype none

module trivium_cipher
    import trivium_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 start,
    input  wire logic [KEY_WIDTH-1:0] key,
    input  wire logic [IV_WIDTH-1:0]  iv,
    input  wire logic                 data_valid,
    input  wire logic [STEP_BITS-1:0] data_in,
    output logic                      ready,
    output logic                      out_valid,
    output logic      [STEP_BITS-1:0] data_out
);

    core_op_t             op;
    logic [STEP_BITS-1:0] ks_byte;

    trivium_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .data_valid (data_valid),
        .data_in    (data_in),
        .ks_byte    (ks_byte),
        .op         (op),
        .ready      (ready),
        .out_valid  (out_valid),
        .data_out   (data_out)
    );

    trivium_core core_i (
        .clk     (clk),
        .rst     (rst),
        .op      (op),
        .key     (key),
        .iv      (iv),
        .ks_byte (ks_byte)
    );

    // A start reloads the core and drops ready with no output on the next cycle
    a_start_restarts: assert property (
        @(posedge clk) disable iff (rst)
        start |=> (ctrl_i.state_q == ST_WARM) && !ready && !out_valid
    );

endmodule

`default_nettype wire

//--- trivium_core.sv
`default_nettype none

module trivium_core
    import trivium_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire core_op_t             op,
    input  wire logic [KEY_WIDTH-1:0] key,
    input  wire logic [IV_WIDTH-1:0]  iv,
    output logic      [STEP_BITS-1:0] ks_byte
);

    logic [STATE_WIDTH-1:0] state_q;
    logic [STATE_WIDTH-1:0] load_state;
    logic [STATE_WIDTH-1:0] step_state;
    logic                   loaded;

    // Bit n of the published s1..s288 numbering
    function automatic logic sbit(input logic [STATE_WIDTH-1:0] st, input int n);
        return st[n-1];
    endfunction

    always_comb begin
        load_state                     = '0;
        load_state[KEY_WIDTH-1:0]      = key;           // s1..s80
        load_state[B_START-1 +: IV_WIDTH] = iv;         // s94..s173
        load_state[STATE_WIDTH-1 -: 3] = 3'b111;        // s286..s288
    end

    // Eight rounds unrolled, ks bit 0 is the first round
    always_comb begin
        logic [STATE_WIDTH-1:0] rnd;
        logic                   ta;
        logic                   tb;
        logic                   tc;

        rnd = state_q;
        ks_byte = '0;
        for (int r = 0; r < STEP_BITS; r++) begin
            ta = sbit(rnd, A_OUT) ^ sbit(rnd, A_END);
            tb = sbit(rnd, B_OUT) ^ sbit(rnd, B_END);
            tc = sbit(rnd, C_OUT) ^ sbit(rnd, C_END);

            ks_byte[r] = ta ^ tb ^ tc;

            ta = ta ^ (sbit(rnd, A_AND0) & sbit(rnd, A_AND1)) ^ sbit(rnd, A_FB);
            tb = tb ^ (sbit(rnd, B_AND0) & sbit(rnd, B_AND1)) ^ sbit(rnd, B_FB);
            tc = tc ^ (sbit(rnd, C_AND0) & sbit(rnd, C_AND1)) ^ sbit(rnd, C_FB);

            // Each register shifts by one, feedback enters at its head
            rnd = {rnd[STATE_WIDTH-2:C_START-1], tb,
                   rnd[C_START-3:B_START-1], ta,
                   rnd[B_START-3:0], tc};
        end
        step_state = rnd;
    end

    always_ff @(posedge clk) begin
        case (op)
            OP_LOAD: state_q <= load_state;
            OP_WARM: state_q <= step_state;
            OP_GEN:  state_q <= step_state;
            OP_HOLD: state_q <= state_q;
            default: state_q <= state_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            loaded <= 1'b0;
        end else if (op == OP_LOAD) begin
            loaded <= 1'b1;
        end
    end

    // The C register tail is loaded with ones, so a dead state means a broken update
    a_state_alive: assert property (
        @(posedge clk) disable iff (rst)
        loaded |-> state_q != '0
    );

endmodule

`default_nettype wire

//--- trivium_ctrl.sv
`default_nettype none

module trivium_ctrl
    import trivium_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 start,
    input  wire logic                 data_valid,
    input  wire logic [STEP_BITS-1:0] data_in,
    input  wire logic [STEP_BITS-1:0] ks_byte,
    output core_op_t                  op,
    output logic                      ready,
    output logic                      out_valid,
    output logic      [STEP_BITS-1:0] data_out
);

    ctrl_state_t               state_q;
    logic [WARM_CNT_WIDTH-1:0] warm_cnt;
    logic                      accept;

    assign ready  = (state_q == ST_READY);
    assign accept = ready && data_valid && !start;      // Start wins

    always_comb begin
        if (start) begin
            op = OP_LOAD;
        end else if (state_q == ST_WARM) begin
            op = OP_WARM;
        end else if (accept) begin
            op = OP_GEN;
        end else begin
            op = OP_HOLD;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= ST_IDLE;
            warm_cnt <= '0;
        end else if (start) begin
            state_q  <= ST_WARM;                        // Restart from any state
            warm_cnt <= '0;
        end else begin
            case (state_q)
                ST_WARM: begin
                    if (warm_cnt == WARM_CNT_WIDTH'(WARMUP_CYCLES - 1)) begin
                        state_q  <= ST_READY;
                        warm_cnt <= '0;
                    end else begin
                        warm_cnt <= warm_cnt + 1'b1;
                    end
                end
                ST_READY: state_q <= ST_READY;
                ST_IDLE:  state_q <= ST_IDLE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            data_out  <= '0;
        end else begin
            out_valid <= accept;
            if (accept) begin
                data_out <= data_in ^ ks_byte;          // Pre-step keystream
            end
        end
    end

    a_warm_cnt_range: assert property (
        @(posedge clk) disable iff (rst)
        warm_cnt < WARMUP_CYCLES
    );

    // Every output byte stands for one keystream step taken in ready
    a_out_after_accept: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> ready && $past(op == OP_GEN)
    );

endmodule

`default_nettype wire

//--- trivium_pkg.sv
`default_nettype none

package trivium_pkg;

    localparam int KEY_WIDTH   = 80;
    localparam int IV_WIDTH    = 80;
    localparam int STATE_WIDTH = 288;
    localparam int STEP_BITS   = 8;     // Rounds per clock, also byte width

    localparam int INIT_ROUNDS    = 1152;
    localparam int WARMUP_CYCLES  = INIT_ROUNDS / STEP_BITS;
    localparam int WARM_CNT_WIDTH = $clog2(WARMUP_CYCLES);

    // First bit of registers B and C, numbered s1..s288
    localparam int B_START = 94;
    localparam int C_START = 178;

    // Round taps, numbered s1..s288
    localparam int A_OUT  = 66;
    localparam int A_END  = 93;
    localparam int A_AND0 = 91;
    localparam int A_AND1 = 92;
    localparam int A_FB   = 171;

    localparam int B_OUT  = 162;
    localparam int B_END  = 177;
    localparam int B_AND0 = 175;
    localparam int B_AND1 = 176;
    localparam int B_FB   = 264;

    localparam int C_OUT  = 243;
    localparam int C_END  = 288;
    localparam int C_AND0 = 286;
    localparam int C_AND1 = 287;
    localparam int C_FB   = 69;

    typedef enum logic [1:0] {
        OP_HOLD = 2'd0,
        OP_LOAD = 2'd1,
        OP_WARM = 2'd2,
        OP_GEN  = 2'd3
    } core_op_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_WARM  = 2'd1,
        ST_READY = 2'd2
    } ctrl_state_t;

endpackage

`default_nettype wire
